//--- Makefile
TOP := tb_ea_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Some tests failed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- common/ea_pkg.sv
package ea_pkg;

    localparam int WIN_DEPTH = 8; // byte queue depth and initial byte credits
    localparam int WIN_PTR_W = $clog2(WIN_DEPTH);
    localparam int NUM_REGS  = 8; // XWA .. XSP

    typedef logic [23:0] addr_t;  // memory address
    typedef logic [31:0] reg_t;   // full register value
    typedef logic [7:0]  rcode_t; // [4:2] register, [1:0] byte lane
    typedef logic [1:0]  step_t;  // 0 -> 1 byte, 1 -> 2, 2 -> 4

    typedef enum logic [1:0] {
        IDLE,
        EXT,
        RESULT,
        WAIT_CREDIT
    } ea_state_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_in_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] index;
        reg_t       value;
    } reg_wr_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        logic [2:0] length;      // bytes consumed
        logic       reg_updated;
    } ea_result_t;

    typedef struct packed {
        logic   valid;
        rcode_t rcode;
        logic   inc;
        logic   dec;
        step_t  step;
    } reg_upd_t;

    // byte count of an auto-update step, code 3 is unused
    function automatic logic [2:0] step_bytes(step_t step);
        case (step)
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            2'd2:    return 3'd4;
            default: return 3'd0;
        endcase
    endfunction

endpackage

//--- design/ea_unit.sv
`timescale 1ns/10ps

module ea_unit (
    input  logic               clk,
    input  logic               rst,
    input  ea_pkg::byte_in_t   byte_in,
    output logic               byte_credit,
    input  ea_pkg::reg_wr_t    reg_wr,
    output ea_pkg::ea_result_t res,
    input  logic               res_credit
);
    import ea_pkg::*;

    logic [31:0] win;
    logic [3:0]  win_count;
    logic        pop;
    logic [2:0]  consume;
    rcode_t      rd_sel, aux_sel;
    reg_t        rd_data, base_sel;
    logic [15:0] aux_data;
    addr_t       offset, addr;
    logic [2:0]  pre_off;
    logic [1:0]  ridx_mode;
    reg_upd_t    reg_upd;

    op_window u_window (
        .clk, .rst, .byte_in, .pop, .win, .win_count
    );

    ea_decode_fsm u_fsm (
        .clk, .rst, .win, .win_count, .pop, .rd_data, .res_credit,
        .rd_sel, .aux_sel, .base_sel, .offset, .pre_off, .ridx_mode,
        .addr, .res, .reg_upd, .consume
    );

    ea_byte_count u_count (
        .clk, .rst, .consume, .pop, .byte_credit
    );

    ea_addr_calc u_calc (
        .clk, .rst, .base(base_sel), .aux_data, .ridx_mode, .offset, .pre_off, .addr
    );

    reg_bank u_regs (
        .clk, .rst, .reg_wr, .rd_sel, .rd_data, .aux_sel, .aux_data, .reg_upd
    );

endmodule

//--- design/op_window.sv
`timescale 1ns/10ps

module op_window (
    input  logic             clk,
    input  logic             rst,
    input  ea_pkg::byte_in_t byte_in,
    input  logic             pop,
    output logic [31:0]      win,
    output logic [3:0]       win_count
);
    import ea_pkg::*;

    logic [7:0]           mem [WIN_DEPTH];
    logic [WIN_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [WIN_PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (byte_in.valid) begin
            mem[wr_ptr] <= byte_in.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (byte_in.valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({byte_in.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // oldest byte in the low lane, stale lanes beyond count are don't care
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            win[8*i +: 8] = mem[rd_ptr + WIN_PTR_W'(i)];
        end
    end

    assign win_count = count;

    // source sent without holding a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        byte_in.valid |-> count < (WIN_PTR_W+1)'(WIN_DEPTH));

endmodule

//--- design/reg_bank.sv
`timescale 1ns/10ps

module reg_bank (
    input  logic             clk,
    input  logic             rst,
    input  ea_pkg::reg_wr_t  reg_wr,
    input  ea_pkg::rcode_t   rd_sel,
    output ea_pkg::reg_t     rd_data,
    input  ea_pkg::rcode_t   aux_sel,
    output logic [15:0]      aux_data,
    input  ea_pkg::reg_upd_t reg_upd
);
    import ea_pkg::*;

    reg_t        regs [NUM_REGS];
    logic [2:0]  upd_idx;
    reg_t        upd_amt;
    reg_t        aux_reg;
    logic [15:0] aux_word;

    assign upd_idx = reg_upd.rcode[4:2];
    assign upd_amt = reg_t'(step_bytes(reg_upd.step));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (reg_wr.valid) begin
                regs[reg_wr.index] <= reg_wr.value;
            end
            if (reg_upd.valid) begin // auto update wins over a load
                if (reg_upd.inc) begin
                    regs[upd_idx] <= regs[upd_idx] + upd_amt;
                end else if (reg_upd.dec) begin
                    regs[upd_idx] <= regs[upd_idx] - upd_amt;
                end
            end
        end
    end

    assign rd_data = regs[rd_sel[4:2]];

    // word by bit 1, odd codes pick the high byte of that word
    always_comb begin
        aux_reg  = regs[aux_sel[4:2]];
        aux_word = aux_sel[1] ? aux_reg[31:16] : aux_reg[15:0];
        if (aux_sel[0]) begin
            aux_data = {8'h00, aux_word[15:8]};
        end else begin
            aux_data = aux_word;
        end
    end

endmodule

//--- files.f
common/ea_pkg.sv
design/op_window.sv
design/reg_bank.sv
idxaddr/ea_byte_count.sv
idxaddr/ea_addr_calc.sv
idxaddr/ea_decode_fsm.sv
design/ea_unit.sv
test/tb_ea_unit.sv

//--- idxaddr/ea_addr_calc.sv
`timescale 1ns/10ps

module ea_addr_calc (
    input  logic          clk,
    input  logic          rst,
    input  ea_pkg::reg_t  base,
    input  logic [15:0]   aux_data,
    input  logic [1:0]    ridx_mode,
    input  ea_pkg::addr_t offset,
    input  logic [2:0]    pre_off,
    output ea_pkg::addr_t addr
);
    import ea_pkg::*;

    addr_t idx_ext;
    addr_t off_sel;

    // index register is signed, r16 when bit 0 set
    always_comb begin
        if (ridx_mode[0]) begin
            idx_ext = {{8{aux_data[15]}}, aux_data};
        end else begin
            idx_ext = {{16{aux_data[7]}}, aux_data[7:0]};
        end
        off_sel = ridx_mode[1] ? idx_ext : offset;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= '0;
        end else begin
            addr <= base[23:0] - addr_t'(pre_off) + off_sel; // pre_off only for (-r32)
        end
    end

endmodule

//--- idxaddr/ea_byte_count.sv
`timescale 1ns/10ps

module ea_byte_count (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] consume,
    output logic       pop,
    output logic       byte_credit
);

    logic [2:0] remaining; // bytes still to drop from the queue

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            remaining <= '0;
        end else if (consume != 3'd0) begin
            remaining <= consume;
        end else if (remaining != 3'd0) begin
            remaining <= remaining - 3'd1;
        end
    end

    assign pop         = remaining != 3'd0; // one byte per cycle
    assign byte_credit = pop;               // each pop frees a queue slot

    // decoder must wait for the previous instruction to drain
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        consume != 3'd0 |-> remaining == 3'd0);

endmodule

//--- idxaddr/ea_decode_fsm.sv
`timescale 1ns/10ps

module ea_decode_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        win,
    input  logic [3:0]         win_count,
    input  logic               pop,
    input  ea_pkg::reg_t       rd_data,
    input  logic               res_credit,
    output ea_pkg::rcode_t     rd_sel,
    output ea_pkg::rcode_t     aux_sel,
    output ea_pkg::reg_t       base_sel,
    output ea_pkg::addr_t      offset,
    output logic [2:0]         pre_off,
    output logic [1:0]         ridx_mode,
    input  ea_pkg::addr_t      addr,
    output ea_pkg::ea_result_t res,
    output ea_pkg::reg_upd_t   reg_upd,
    output logic [2:0]         consume
);
    import ea_pkg::*;

    typedef struct packed {
        rcode_t     rd;
        rcode_t     aux;
        addr_t      off;
        logic [1:0] ridx;
        logic       use_base; // zero base for absolute modes
        logic [2:0] len;
        logic       inc;
        logic       dec;
        step_t      step;
    } dec_fields_t;

    ea_state_t   state, nx_state;
    dec_fields_t dq, nx_dq, cand, ext_cand;
    logic [2:0]  need, ext_need;
    logic        go_ext;
    logic        issue;
    logic [7:0]  res_cnt;
    logic [7:0]  b0, b1, b2, b3;

    assign b0 = win[7:0];
    assign b1 = win[15:8];
    assign b2 = win[23:16];
    assign b3 = win[31:24];

    // first byte: mode from bit 6 and bits 3..0
    always_comb begin
        cand   = '0;
        need   = 3'd1;
        go_ext = 1'b0;
        casez ({b0[6], b0[3:0]})
            5'b0_????: begin // (r32) and (r32+d8) short code
                cand.rd       = {3'b111, b0[2:0], 2'b00};
                cand.use_base = 1'b1;
                cand.off      = b0[3] ? {{16{b1[7]}}, b1} : '0;
                cand.len      = b0[3] ? 3'd2 : 3'd1;
                need          = cand.len;
            end
            5'h10: begin
                cand.off = {16'd0, b1};
                cand.len = 3'd2;
                need     = 3'd2;
            end
            5'h11: begin
                cand.off = {8'd0, b2, b1};
                cand.len = 3'd3;
                need     = 3'd3;
            end
            5'h12: begin
                cand.off = {b3, b2, b1};
                cand.len = 3'd4;
                need     = 3'd4;
            end
            5'h13: begin // second byte decides, see EXT
                cand.use_base = 1'b1;
                need          = 3'd2;
                go_ext        = 1'b1;
            end
            5'h14, 5'h15: begin // (-r32) and (r32+)
                cand.rd       = {b1[7:2], 2'b00};
                cand.use_base = 1'b1;
                cand.dec      = ~b0[0];
                cand.inc      = b0[0];
                cand.step     = b1[1:0];
                cand.len      = 3'd2;
                need          = 3'd2;
            end
            default: cand.len = 3'd1; // not a memory form, drop one byte
        endcase
    end

    // second byte mode field of the extended forms
    always_comb begin
        ext_cand     = dq;
        ext_cand.rd  = {b1[7:2], 2'b00};
        ext_cand.off = '0;
        ext_cand.len = 3'd2;
        ext_need     = 3'd2;
        case (b1[1:0])
            2'd1: begin // (r32+d16)
                ext_cand.off = {{8{b3[7]}}, b3, b2};
                ext_cand.len = 3'd4;
                ext_need     = 3'd4;
            end
            2'd3: begin // (r32+r8) or (r32+r16)
                ext_cand.rd   = b2;
                ext_cand.aux  = b3;
                ext_cand.ridx = {1'b1, b1[2]};
                ext_cand.len  = 3'd4;
                ext_need      = 3'd4;
            end
            default: ;
        endcase
    end

    assign issue = (state == WAIT_CREDIT) && (res_cnt != 8'd0);

    always_comb begin
        nx_state = state;
        nx_dq    = dq;
        case (state)
            IDLE: begin
                if (!pop && win_count >= {1'b0, need}) begin // old bytes gone first
                    nx_dq    = cand;
                    nx_state = go_ext ? EXT : RESULT;
                end
            end
            EXT: begin
                if (win_count >= {1'b0, ext_need}) begin
                    nx_dq    = ext_cand;
                    nx_state = RESULT;
                end
            end
            RESULT:      nx_state = WAIT_CREDIT; // adder registers here
            WAIT_CREDIT: nx_state = issue ? IDLE : WAIT_CREDIT;
            default:     nx_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            dq      <= '0;
            res_cnt <= '0;
        end else begin
            state <= nx_state;
            dq    <= nx_dq;
            case ({res_credit, issue})
                2'b10:   res_cnt <= res_cnt + 8'd1;
                2'b01:   res_cnt <= res_cnt - 8'd1;
                default: ;
            endcase
        end
    end

    assign rd_sel    = dq.rd;
    assign aux_sel   = dq.aux;
    assign base_sel  = dq.use_base ? rd_data : '0;
    assign offset    = dq.off;
    assign ridx_mode = dq.ridx;
    assign pre_off   = dq.dec ? step_bytes(dq.step) : 3'd0;

    assign res.valid       = issue;
    assign res.addr        = addr;
    assign res.length      = dq.len;
    assign res.reg_updated = dq.inc | dq.dec;

    assign reg_upd.valid = issue & (dq.inc | dq.dec);
    assign reg_upd.rcode = dq.rd;
    assign reg_upd.inc   = dq.inc;
    assign reg_upd.dec   = dq.dec;
    assign reg_upd.step  = dq.step;

    assign consume = issue ? dq.len : 3'd0;

    // the whole instruction sits in the queue when it is released
    a_consume_covered: assert property (@(posedge clk) disable iff (rst)
        {1'b0, consume} <= win_count);

endmodule

//--- test/tb_ea_unit.sv
`timescale 1ns/10ps

module tb_ea_unit;
    import ea_pkg::*;

    localparam int NUM_RANDOM       = 48;
    localparam int CYCLES_PER_INSTR = 200;

    logic       clk;
    logic       rst;
    byte_in_t   byte_in;
    logic       byte_credit;
    reg_wr_t    reg_wr;
    ea_result_t res;
    logic       res_credit;

    logic [31:0] lcg_state;
    reg_t        init_regs [NUM_REGS];
    reg_t        model_regs [NUM_REGS]; // register state as the reference sees it
    logic [7:0]  byte_q [$];
    logic [27:0] exp_q [$];              // {addr, length, reg_updated}
    logic [27:0] exp_e;
    logic        src_en;
    int          n_instr, errors, checks, cycles, cycle_limit;
    int          src_credits, bytes_sent, bytes_returned;
    int          granted, received, credits_seen;

    ea_unit i_dut (
        .clk, .rst, .byte_in, .byte_credit, .reg_wr, .res, .res_credit
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16]; // low bits of an LCG repeat too fast
    endfunction

    function automatic logic [31:0] rand_word();
        return {rand_byte(), rand_byte(), rand_byte(), rand_byte()};
    endfunction

    function automatic logic [31:0] step_size(logic [1:0] code);
        case (code)
            2'd0:    return 32'd1;
            2'd1:    return 32'd2;
            default: return 32'd4;
        endcase
    endfunction

    function automatic logic [23:0] sext8(logic [7:0] v);
        return {{16{v[7]}}, v};
    endfunction

    function automatic logic [23:0] sext16(logic [15:0] v);
        return {{8{v[15]}}, v};
    endfunction

    // expected address, length and update flag with auto updates applied to model_regs
    function automatic logic [27:0] ref_ea(logic [31:0] w);
        logic [7:0]  b0, b1, b2, b3;
        logic [2:0]  r;
        logic [15:0] word;
        logic [23:0] a;
        logic [2:0]  len;
        logic        upd;
        b0  = w[7:0];
        b1  = w[15:8];
        b2  = w[23:16];
        b3  = w[31:24];
        r   = b1[4:2];
        a   = '0;
        len = 3'd2;
        upd = 1'b0;
        if (!b0[6]) begin
            a   = model_regs[b0[2:0]][23:0] + (b0[3] ? sext8(b1) : 24'd0);
            len = b0[3] ? 3'd2 : 3'd1;
        end else begin
            case (b0[3:0])
                4'h0: a = {16'd0, b1};
                4'h1: begin
                    a   = {8'd0, b2, b1};
                    len = 3'd3;
                end
                4'h2: begin
                    a   = {b3, b2, b1};
                    len = 3'd4;
                end
                4'h3: begin
                    a = model_regs[r][23:0];
                    if (b1[1:0] == 2'd1) begin // d16
                        a   = a + sext16({b3, b2});
                        len = 3'd4;
                    end else if (b1[1:0] == 2'd3) begin // index register
                        word = b3[1] ? model_regs[b3[4:2]][31:16] : model_regs[b3[4:2]][15:0];
                        a    = model_regs[b2[4:2]][23:0];
                        if (b1[2]) begin
                            a = a + sext16(word);
                        end else begin
                            a = a + sext8(b3[0] ? word[15:8] : word[7:0]);
                        end
                        len = 3'd4;
                    end
                end
                4'h4: begin
                    model_regs[r] = model_regs[r] - step_size(b1[1:0]);
                    a             = model_regs[r][23:0];
                    upd           = 1'b1;
                end
                4'h5: begin
                    a             = model_regs[r][23:0];
                    model_regs[r] = model_regs[r] + step_size(b1[1:0]);
                    upd           = 1'b1;
                end
                default: len = 3'd1;
            endcase
        end
        return {a, len, upd};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [7:0] b0, b1, b2, b3, kind, st;
        b0   = rand_byte();
        b1   = rand_byte();
        b2   = rand_byte();
        b3   = rand_byte();
        kind = rand_byte() % 8'd10;
        st   = rand_byte() % 8'd3; // step code 3 is not a legal step
        case (kind)
            8'd0: b0 = b0 & 8'hb7;
            8'd1: b0 = (b0 & 8'hbf) | 8'h08;
            8'd2: b0 = (b0 & 8'hb0) | 8'h40;
            8'd3: b0 = (b0 & 8'hb0) | 8'h41;
            8'd4: b0 = (b0 & 8'hb0) | 8'h42;
            8'd5: begin
                b0 = (b0 & 8'hb0) | 8'h43;
                b1 = (b1 & 8'hfc) | 8'h01;
            end
            8'd6: begin
                b0 = (b0 & 8'hb0) | 8'h43;
                b1 = (b1 & 8'hf8) | 8'h03;
            end
            8'd7: begin
                b0 = (b0 & 8'hb0) | 8'h43;
                b1 = (b1 & 8'hf8) | 8'h07;
                b3 = b3 & 8'hfe; // r16 index on an even code
            end
            8'd8: begin
                b0 = (b0 & 8'hb0) | 8'h44;
                b1 = (b1 & 8'hfc) | st;
            end
            default: begin
                b0 = (b0 & 8'hb0) | 8'h45;
                b1 = (b1 & 8'hfc) | st;
            end
        endcase
        return {b3, b2, b1, b0};
    endfunction

    task automatic push_instr(input logic [31:0] w);
        logic [27:0] e;
        e = ref_ea(w);
        for (int i = 0; i < int'(e[3:1]); i++) begin
            byte_q.push_back(w[8*i +: 8]);
        end
        exp_q.push_back(e);
        n_instr++;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // byte source spending one credit per byte
    always @(negedge clk) begin
        if (!rst) begin
            if (src_en && byte_q.size() > 0 && src_credits > 0) begin
                byte_in.valid = 1'b1;
                byte_in.data  = byte_q.pop_front();
                src_credits--;
                bytes_sent++;
            end else begin
                byte_in = '0;
            end
            if (byte_credit) begin // usable from the next cycle on
                src_credits++;
                bytes_returned++;
            end
            if (bytes_returned > bytes_sent) begin
                errors++;
                $display("byte credits out of balance: %0d sent, %0d returned",
                         bytes_sent, bytes_returned);
            end
        end
    end

    // result credits as the DUT samples them
    always @(posedge clk) begin
        if (!rst && res_credit) begin
            credits_seen++;
        end
    end

    always @(negedge clk) begin
        if (!rst && res.valid) begin
            if (received >= credits_seen) begin
                errors++;
                $display("a result came out without a result credit");
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("a result came out with no instruction pending");
            end else begin
                exp_e = exp_q.pop_front();
                check("res.addr", 32'(res.addr), 32'(exp_e[27:4]));
                check("res.length", 32'(res.length), 32'(exp_e[3:1]));
                check("res.reg_updated", 32'(res.reg_updated), 32'(exp_e[0]));
            end
            received++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results seen",
                     cycles, received, n_instr);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [7:0] r;
        rst         = 1'b1;
        byte_in     = '0;
        reg_wr      = '0;
        res_credit  = 1'b0;
        src_en      = 1'b0;
        lcg_state   = 32'hb762;
        src_credits = WIN_DEPTH;
        for (int i = 0; i < NUM_REGS; i++) begin
            init_regs[i]  = rand_word();
            model_regs[i] = init_regs[i];
        end
        push_instr(32'h0000_0002);     // (xde)
        push_instr(32'h0000_f00a);     // (xde-16)
        push_instr(32'h0000_9c40);     // abs8
        push_instr(32'h0034_1241);     // abs16
        push_instr(32'h1234_5642);     // abs24
        push_instr(32'h8000_1543);     // (xiy+d16) negative
        push_instr(32'h1904_0343);     // (xbc+r8) high byte lane
        push_instr(32'h0a1c_0743);     // (xsp+r16) upper word
        push_instr(32'h0000_0e44);     // (-xhl) by 4
        push_instr(32'h0000_0003);     // then (xhl)
        push_instr(32'h0000_1145);     // (xix+) by 2
        push_instr(32'h0000_100c);     // then (xix+16)
        for (int i = 0; i < NUM_RANDOM; i++) begin
            push_instr(random_instr());
        end
        cycle_limit = CYCLES_PER_INSTR * n_instr;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            @(negedge clk);
            reg_wr = {1'b1, 3'(i), init_regs[i]};
        end
        @(negedge clk);
        reg_wr = '0;
        src_en = 1'b1;
        repeat (60) @(negedge clk);
        check("results while credits withheld", 32'(received), 32'd0);
        while (granted < n_instr) begin
            @(negedge clk);
            r          = rand_byte();
            res_credit = r[0];
            if (res_credit) begin
                granted++;
            end
        end
        @(negedge clk);
        res_credit = 1'b0;
        while (received < n_instr || bytes_returned < bytes_sent || byte_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check("results received", 32'(received), 32'(n_instr));
        check("byte_credit pulses", 32'(bytes_returned), 32'(bytes_sent));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
